/* common/apb_pkg.sv */
package apb_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int addr_w = 32;
  localparam int data_w = 32;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  localparam int ram_words      = 32;
  localparam int ram_bank_words = 8;
  localparam int ram_idx_w      = $clog2(ram_words);
  localparam int ram_banks      = ram_words / ram_bank_words;
  localparam int ram_bank_w     = $clog2(ram_banks);

  // Bit 12 splits RAM from registers, bits above must be zero
  localparam int region_lsb = 12;
  localparam logic [addr_w-1:0] reg_base = 32'h0000_1000;

  localparam logic [region_lsb-1:0] reg_ctrl_off   = 12'h000;
  localparam logic [region_lsb-1:0] reg_errcnt_off = 12'h004;
  localparam logic [region_lsb-1:0] reg_id_off     = 12'h008;

  localparam logic [data_w-1:0] subsys_id = 32'h5AB5_0001;

  // pslverr values
  localparam logic resp_okay   = 1'b0;
  localparam logic resp_slverr = 1'b1;

  ////////////////////////////////////////
  // CTRL register layout
  ////////////////////////////////////////
  typedef struct packed {
    logic [data_w-ram_banks-1:0] rsvd;
    logic [ram_banks-1:0]        wp_mask;
  } ctrl_fields_t;

  typedef union packed {
    logic [data_w-1:0] raw;
    ctrl_fields_t      fields;
  } ctrl_word_u;

endpackage

/* common/apb_bus_if.sv */
`timescale 1ns/1ns

interface apb_bus_if
  import apb_pkg::*;
();

  // Request side
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;

  // Response side, valid only while pready is high
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

/* design/apb_decoder.sv */
`timescale 1ns/1ns

module apb_decoder
  import apb_pkg::*;
(
  input  logic              pclk,
  input  logic              presetn,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  apb_bus_if.requester      ram_bus,
  apb_bus_if.requester      reg_bus
);

  logic hit_ram;
  logic hit_reg;
  logic err_ready;

  // Region decode, paddr is held from setup until pready
  assign hit_ram = (paddr[addr_w-1:region_lsb] == '0);
  assign hit_reg = (paddr[addr_w-1:region_lsb] == reg_base[addr_w-1:region_lsb]);

  ////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////
  // Only the selected completer sees psel
  assign ram_bus.psel    = psel & hit_ram;
  assign ram_bus.penable = penable;
  assign ram_bus.pwrite  = pwrite;
  assign ram_bus.paddr   = paddr;
  assign ram_bus.pwdata  = pwdata;

  assign reg_bus.psel    = psel & hit_reg;
  assign reg_bus.penable = penable;
  assign reg_bus.pwrite  = pwrite;
  assign reg_bus.paddr   = paddr;
  assign reg_bus.pwdata  = pwdata;

  ////////////////////////////////////////
  // Own reply for unmapped addresses
  ////////////////////////////////////////
  // One wait state, same as the completers
  always_ff @(posedge pclk)
  begin
    if (!presetn)
      err_ready <= 1'b0;
    else if (psel && penable && !hit_ram && !hit_reg && !err_ready)
      err_ready <= 1'b1;
    else
      err_ready <= 1'b0;
  end

  // Response return
  always_comb
  begin
    if (hit_ram)
    begin
      prdata  = ram_bus.prdata;
      pready  = ram_bus.pready;
      pslverr = ram_bus.pslverr;
    end
    else if (hit_reg)
    begin
      prdata  = reg_bus.prdata;
      pready  = reg_bus.pready;
      pslverr = reg_bus.pslverr;
    end
    else
    begin
      prdata  = '0;
      pready  = err_ready;
      pslverr = err_ready ? resp_slverr : resp_okay;
    end
  end

endmodule

/* apb_ram/apb_ram.sv */
`timescale 1ns/1ns

module apb_ram
  import apb_pkg::*;
(
  input  logic                 pclk,
  input  logic                 presetn,
  apb_bus_if.completer         bus,
  input  logic [ram_banks-1:0] wp_mask,
  output logic                 ram_err_pulse
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_transfer
  } state_t;

  state_t state;

  logic [data_w-1:0]     mem [ram_words];
  logic [ram_idx_w-1:0]  word_idx;
  logic [ram_bank_w-1:0] bank;
  logic                  range_err;
  logic                  align_err;
  logic                  prot_err;
  logic                  any_err;

  ////////////////////////////////////////
  // Address checks
  ////////////////////////////////////////
  assign word_idx = bus.paddr[ram_idx_w+1:2];

  // Top bits of the word index pick the bank
  assign bank = word_idx[ram_idx_w-1 -: ram_bank_w];

  // Bits between the word index and the region bit must be zero
  assign range_err = (bus.paddr[region_lsb-1:ram_idx_w+2] != '0);
  assign align_err = (bus.paddr[1:0] != 2'b00);
  assign prot_err  = bus.pwrite & wp_mask[bank];
  assign any_err   = range_err | align_err | prot_err;

  // One pulse per error response
  assign ram_err_pulse = bus.pready & bus.pslverr;

  ////////////////////////////////////////
  // Transfer FSM and storage
  ////////////////////////////////////////
  always_ff @(posedge pclk)
  begin
    if (!presetn)
    begin
      state       <= st_idle;
      bus.prdata  <= '0;
      bus.pready  <= 1'b0;
      bus.pslverr <= resp_okay;
      for (int i = 0; i < ram_words; i++)
        mem[i] <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          bus.prdata  <= '0;
          bus.pready  <= 1'b0;
          bus.pslverr <= resp_okay;
          // A transfer may start right after reset
          state <= (bus.psel && !bus.penable) ? st_access : st_setup;
        end

        st_setup:
        begin
          if (bus.psel && !bus.penable)
            state <= st_access;
        end

        // First access cycle, reply lands in the next one
        st_access:
        begin
          if (bus.psel && bus.penable)
          begin
            state      <= st_transfer;
            bus.pready <= 1'b1;
            if (any_err)
            begin
              bus.pslverr <= resp_slverr;
              bus.prdata  <= '0;
            end
            else
            begin
              bus.pslverr <= resp_okay;
              if (bus.pwrite)
                mem[word_idx] <= bus.pwdata;
              else
                bus.prdata <= mem[word_idx];
            end
          end
          else
            state <= st_setup;
        end

        st_transfer:
        begin
          state       <= st_setup;
          bus.pready  <= 1'b0;
          bus.pslverr <= resp_okay;
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* apb_ram/ram_ctrl_regs.sv */
`timescale 1ns/1ns

module ram_ctrl_regs
  import apb_pkg::*;
(
  input  logic                 pclk,
  input  logic                 presetn,
  apb_bus_if.completer         bus,
  input  logic                 ram_err_pulse,
  output logic [ram_banks-1:0] wp_mask
);

  logic [ram_banks-1:0]  ctrl_wp;
  logic [data_w-1:0]     err_cnt;
  logic [region_lsb-1:0] reg_off;
  logic                  access_now;
  logic                  off_err;
  logic [data_w-1:0]     rd_data;
  ctrl_word_u            wr_word;
  ctrl_word_u            rd_word;

  assign reg_off = bus.paddr[region_lsb-1:0];

  // Second access cycle raises pready, so sample only once
  assign access_now = bus.psel & bus.penable & ~bus.pready;

  // CTRL views of the bus words
  assign wr_word.raw = bus.pwdata;

  always_comb
  begin
    rd_word                = '0;
    rd_word.fields.wp_mask = ctrl_wp;
  end

  assign wp_mask = ctrl_wp;

  ////////////////////////////////////////
  // Offset decode
  ////////////////////////////////////////
  always_comb
  begin
    off_err = 1'b0;
    rd_data = '0;
    case (reg_off)
      reg_ctrl_off:   rd_data = rd_word.raw;
      reg_errcnt_off: rd_data = err_cnt;
      reg_id_off:
      begin
        rd_data = subsys_id;
        // ID is read only
        off_err = bus.pwrite;
      end
      default:        off_err = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Registers and response
  ////////////////////////////////////////
  always_ff @(posedge pclk)
  begin
    if (!presetn)
    begin
      ctrl_wp     <= '0;
      err_cnt     <= '0;
      bus.pready  <= 1'b0;
      bus.pslverr <= resp_okay;
      bus.prdata  <= '0;
    end
    else
    begin
      // Saturating count of RAM errors
      if (ram_err_pulse && (err_cnt != '1))
        err_cnt <= err_cnt + 1'b1;

      bus.pready  <= access_now;
      bus.pslverr <= resp_okay;

      if (access_now)
      begin
        bus.pslverr <= off_err ? resp_slverr : resp_okay;
        bus.prdata  <= (off_err || bus.pwrite) ? '0 : rd_data;
        if (bus.pwrite && !off_err)
        begin
          if (reg_off == reg_ctrl_off)
            ctrl_wp <= wr_word.fields.wp_mask;
          // Any write value clears the count
          if (reg_off == reg_errcnt_off)
            err_cnt <= '0;
        end
      end
    end
  end

endmodule

/* design/apb_subsys_top.sv */
`timescale 1ns/1ns

module apb_subsys_top
  import apb_pkg::*;
(
  input  logic              pclk,
  input  logic              presetn,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // Side-band between registers and RAM
  logic [ram_banks-1:0] wp_mask;
  logic                 ram_err_pulse;

  apb_bus_if ram_bus ();
  apb_bus_if reg_bus ();

  apb_decoder decoder0 (
    .pclk    (pclk),
    .presetn (presetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ram_bus (ram_bus.requester),
    .reg_bus (reg_bus.requester)
  );

  apb_ram ram0 (
    .pclk          (pclk),
    .presetn       (presetn),
    .bus           (ram_bus.completer),
    .wp_mask       (wp_mask),
    .ram_err_pulse (ram_err_pulse)
  );

  ram_ctrl_regs regs0 (
    .pclk          (pclk),
    .presetn       (presetn),
    .bus           (reg_bus.completer),
    .ram_err_pulse (ram_err_pulse),
    .wp_mask       (wp_mask)
  );

endmodule

/* tests/apb_subsys_asserts.sv */
`timescale 1ns/1ns

module apb_subsys_asserts
  import apb_pkg::*;
(
  input logic              pclk,
  input logic              presetn,
  input logic              psel,
  input logic              penable,
  input logic [addr_w-1:0] paddr,
  input logic              pready,
  input logic              pslverr
);

  int fail_count = 0;

  // Error reply only together with ready
  slverr_with_ready: assert property (
    @(posedge pclk) disable iff (!presetn) pslverr |-> pready
  )
  else
  begin
    $error("pslverr high without pready");
    fail_count++;
  end

  ready_in_access: assert property (
    @(posedge pclk) disable iff (!presetn) pready |-> (psel && penable)
  )
  else
  begin
    $error("pready high outside the access phase");
    fail_count++;
  end

  // Address held until the completer answers
  addr_stable: assert property (
    @(posedge pclk) disable iff (!presetn) (psel && !pready) |=> $stable(paddr)
  )
  else
  begin
    $error("paddr changed before pready");
    fail_count++;
  end

endmodule

bind apb_subsys_top apb_subsys_asserts asserts0 (
  .pclk    (pclk),
  .presetn (presetn),
  .psel    (psel),
  .penable (penable),
  .paddr   (paddr),
  .pready  (pready),
  .pslverr (pslverr)
);

/* tests/tb_apb_subsys.sv */
`timescale 1ns/1ns

module tb_apb_subsys
  import apb_pkg::*;
();

  logic              pclk;
  logic              presetn;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;

  integer            seed;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                exp_err_cnt = 0;
  int                max_xfers = 100;
  logic [data_w-1:0] model [ram_words];

  apb_subsys_top dut0 (.*);

  initial
  begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  // Three cycles per transfer, plus reset and some slack
  initial
  begin
    #((4 + max_xfers * 3 + 20) * 100);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_resp(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_ctrl(input string name, input ctrl_word_u exp, input ctrl_word_u act);
    if (act.raw !== exp.raw)
    begin
      $display("CHECK FAILED at %0t ns: %s expected wp_mask %b (%h), got wp_mask %b (%h)",
               $time, name, exp.fields.wp_mask, exp.raw, act.fields.wp_mask, act.raw);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////
  task automatic apb_xfer(input logic wr, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] wdata,
                          output logic [data_w-1:0] rdata, output logic resp);
    int cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge pclk);
    #1;
    penable = 1'b1;
    cycles  = 2;
    while (!pready && cycles < 10)
    begin
      @(posedge pclk);
      #1;
      cycles++;
    end
    rdata = prdata;
    resp  = pslverr;
    if (cycles != 3)
    begin
      $display("Transfer to %h took %0d cycles from setup to pready instead of three",
               addr, cycles);
      fail_cnt++;
    end
    // Transfer ends on the edge that sees pready
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                           output logic [data_w-1:0] rdata, output logic resp);
    apb_xfer(1'b1, addr, wdata, rdata, resp);
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] rdata,
                          output logic resp);
    apb_xfer(1'b0, addr, '0, rdata, resp);
  endtask

  task automatic read_expect(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp_data,
                             input logic exp_resp);
    logic [data_w-1:0] data;
    logic              resp;
    apb_read(addr, data, resp);
    check_resp($sformatf("pslverr @%h", addr), exp_resp, resp);
    check_data($sformatf("prdata @%h", addr), exp_data, data);
  endtask

  // prdata only matters on a write when it is an error reply
  task automatic write_expect(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                              input logic exp_resp);
    logic [data_w-1:0] data;
    logic              resp;
    apb_write(addr, wdata, data, resp);
    check_resp($sformatf("pslverr @%h", addr), exp_resp, resp);
    if (exp_resp == resp_slverr)
      check_data($sformatf("prdata @%h", addr), '0, data);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%-22s %s", name, (fail_cnt == errs_before) ? "passed" : "FAILED");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_reset_defaults();
    int errs;
    errs = fail_cnt;
    read_expect(32'h0000_0000, '0, resp_okay);
    read_expect(32'h0000_007C, '0, resp_okay);
    read_expect(reg_base + reg_ctrl_off, '0, resp_okay);
    read_expect(reg_base + reg_errcnt_off, '0, resp_okay);
    read_expect(reg_base + reg_id_off, subsys_id, resp_okay);
    report_test("reset defaults", errs);
  endtask

  task automatic test_ram_data();
    int errs;
    errs = fail_cnt;
    for (int i = 0; i < ram_words; i++)
    begin
      model[i] = $random(seed);
      write_expect(i * 4, model[i], resp_okay);
    end
    for (int i = 0; i < ram_words; i++)
      read_expect(i * 4, model[i], resp_okay);
    report_test("ram data", errs);
  endtask

  task automatic test_ram_errors();
    int errs;
    errs = fail_cnt;
    // Word 32 would alias word 0 without the range check
    write_expect(32'h0000_0080, ~model[0], resp_slverr);
    read_expect(32'h0000_0002, '0, resp_slverr);
    exp_err_cnt += 2;
    read_expect(32'h0000_0000, model[0], resp_okay);
    read_expect(reg_base + reg_errcnt_off, exp_err_cnt, resp_okay);
    report_test("ram address errors", errs);
  endtask

  task automatic test_write_protect();
    int                errs;
    ctrl_word_u        exp_ctrl;
    ctrl_word_u        got;
    logic [data_w-1:0] data;
    logic              resp;
    errs     = fail_cnt;
    exp_ctrl = '0;
    exp_ctrl.fields.wp_mask = 4'b0010;
    write_expect(reg_base + reg_ctrl_off, exp_ctrl.raw, resp_okay);
    apb_read(reg_base + reg_ctrl_off, data, resp);
    got.raw = data;
    check_resp("pslverr @ctrl", resp_okay, resp);
    check_ctrl("ctrl", exp_ctrl, got);
    // Bank 1 holds words 8 to 15
    write_expect(9 * 4, ~model[9], resp_slverr);
    exp_err_cnt++;
    read_expect(9 * 4, model[9], resp_okay);
    model[3] = $random(seed);
    write_expect(3 * 4, model[3], resp_okay);
    read_expect(3 * 4, model[3], resp_okay);
    write_expect(reg_base + reg_ctrl_off, '0, resp_okay);
    model[9] = $random(seed);
    write_expect(9 * 4, model[9], resp_okay);
    read_expect(9 * 4, model[9], resp_okay);
    report_test("write protect", errs);
  endtask

  task automatic test_reg_errors();
    int errs;
    errs = fail_cnt;
    read_expect(reg_base | 32'h0000_000C, '0, resp_slverr);
    write_expect(reg_base + reg_id_off, $random(seed), resp_slverr);
    read_expect(32'h0000_2000, '0, resp_slverr);
    // Only RAM errors are counted
    read_expect(reg_base + reg_errcnt_off, exp_err_cnt, resp_okay);
    report_test("register errors", errs);
  endtask

  task automatic test_counter_clear();
    int errs;
    errs = fail_cnt;
    write_expect(reg_base + reg_errcnt_off, $random(seed), resp_okay);
    exp_err_cnt = 0;
    read_expect(reg_base + reg_errcnt_off, exp_err_cnt, resp_okay);
    report_test("counter clear", errs);
  endtask

  initial
  begin
    seed    = 59883;
    presetn = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge pclk);
    #1;
    presetn = 1'b1;

    test_reset_defaults();
    test_ram_data();
    test_ram_errors();
    test_write_protect();
    test_reg_errors();
    test_counter_clear();

    $display("Summary: passed %0d, failed %0d, assertion errors %0d",
             pass_cnt, fail_cnt, dut0.asserts0.fail_count);
    if (fail_cnt == 0 && dut0.asserts0.fail_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* sim.f */
common/apb_pkg.sv
common/apb_bus_if.sv
design/apb_decoder.sv
apb_ram/apb_ram.sv
apb_ram/ram_ctrl_regs.sv
design/apb_subsys_top.sv
tests/apb_subsys_asserts.sv
tests/tb_apb_subsys.sv

/* Bender.yml */
package:
  name: apb_subsys

sources:
  - common/apb_pkg.sv
  - common/apb_bus_if.sv
  - design/apb_decoder.sv
  - apb_ram/apb_ram.sv
  - apb_ram/ram_ctrl_regs.sv
  - design/apb_subsys_top.sv
  - target: test
    files:
      - tests/apb_subsys_asserts.sv
      - tests/tb_apb_subsys.sv
